//--- hdl/mips_pkg.sv
package mips_pkg;

	localparam int c_xlen = 32;
	localparam int c_reg_addr_w = 5;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lh      = 6'h21,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} t_opcode;

	// function field of special opcode
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a
	} t_funct;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_lui,
		alu_pass_b
	} t_alu_op;

	typedef enum logic [1:0] {
		ld_word,
		ld_half,
		ld_byte
	} t_load_kind;

endpackage

//--- hdl/fetch.sv
`timescale 1ns/100ps

module fetch import mips_pkg::*; #(
	parameter logic [c_xlen-1:0] P_RESET_ADDR = 32'h0000_0000
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_stall,
	input  logic              i_branch_taken,
	input  logic [c_xlen-1:0] i_branch_target,
	input  logic              i_jump,
	input  logic [c_xlen-1:0] i_jump_target,
	input  logic [c_xlen-1:0] i_instr,
	output logic [c_xlen-1:0] o_instr_addr,
	output logic [c_xlen-1:0] o_pc4,
	output logic [c_xlen-1:0] o_instr_d
);

	logic [c_xlen-1:0] pc;
	logic [c_xlen-1:0] pc_plus4;
	logic [c_xlen-1:0] pc_next;

	assign pc_plus4 = pc + 32'd4;
	assign o_instr_addr = pc;

	// decode already drops branch and jump while it stalls
	always_comb begin
		if (i_stall) begin
			pc_next = pc;
		end else if (i_jump) begin
			pc_next = i_jump_target;
		end else if (i_branch_taken) begin
			pc_next = i_branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// instruction word 0 is sll r0,r0,0, so reset leaves a nop in decode
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= P_RESET_ADDR;
			o_instr_d <= '0;
		end else if (!i_stall) begin
			pc <= pc_next;
			o_instr_d <= i_instr;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_stall) begin
			o_pc4 <= pc_plus4;
		end
	end

	a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		pc[1:0] == 2'b00);

endmodule

//--- hdl/decode.sv
`timescale 1ns/100ps

module decode import mips_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [c_xlen-1:0]       i_instr,
	input  logic [c_xlen-1:0]       i_pc4,
	input  logic                    i_wb_we,
	input  logic [c_reg_addr_w-1:0] i_wb_dst,
	input  logic [c_xlen-1:0]       i_wb_data,
	input  logic [c_xlen-1:0]       i_m_alu_res,
	input  logic [c_reg_addr_w-1:0] i_m_dst,
	input  logic                    i_m_we,
	input  logic                    i_m_load,
	input  logic [c_reg_addr_w-1:0] i_e_dst,
	input  logic                    i_e_we,
	input  logic                    i_e_load,
	output logic                    o_stall,
	output logic                    o_branch_taken,
	output logic [c_xlen-1:0]       o_branch_target,
	output logic                    o_jump,
	output logic [c_xlen-1:0]       o_jump_target,
	output logic [c_xlen-1:0]       o_rs_data,
	output logic [c_xlen-1:0]       o_rt_data,
	output logic [c_reg_addr_w-1:0] o_rs,
	output logic [c_reg_addr_w-1:0] o_rt,
	output logic [c_reg_addr_w-1:0] o_rd,
	output logic [c_xlen-1:0]       o_imm,
	output logic [c_xlen-1:0]       o_pc4,
	output t_alu_op                 o_alu_op,
	output logic                    o_alu_src,
	output logic                    o_reg_dst,
	output logic                    o_link,
	output logic                    o_mem_read,
	output logic                    o_mem_write,
	output t_load_kind              o_load_kind,
	output logic                    o_mem_to_reg,
	output logic                    o_reg_we
);

	logic [c_xlen-1:0] rf [32];

	t_opcode opcode;
	t_funct funct;
	logic [c_reg_addr_w-1:0] rs;
	logic [c_reg_addr_w-1:0] rt;
	logic [c_reg_addr_w-1:0] rd;
	logic [c_xlen-1:0] imm_ext;
	logic [c_xlen-1:0] rs_rf;
	logic [c_xlen-1:0] rt_rf;
	logic [c_xlen-1:0] rs_val;
	logic [c_xlen-1:0] rt_val;

	t_alu_op alu_op;
	t_load_kind load_kind;
	logic alu_src;
	logic reg_dst;
	logic link;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic reg_we;
	logic is_beq;
	logic is_bne;
	logic is_jimm;
	logic is_jr;
	logic use_rs;
	logic use_rt;
	logic zero_ext;
	logic load_use;
	logic br_hazard;

	assign opcode = t_opcode'(i_instr[31:26]);
	assign funct = t_funct'(i_instr[5:0]);
	assign rs = i_instr[25:21];
	assign rt = i_instr[20:16];
	assign rd = i_instr[15:11];
	assign imm_ext = zero_ext ? {16'h0000, i_instr[15:0]} : {{16{i_instr[15]}}, i_instr[15:0]};

	always_comb begin
		alu_op = alu_add;
		alu_src = 1'b0;
		reg_dst = 1'b0;
		link = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		load_kind = ld_word;
		mem_to_reg = 1'b0;
		reg_we = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jimm = 1'b0;
		is_jr = 1'b0;
		use_rs = 1'b0;
		use_rt = 1'b0;
		zero_ext = 1'b0;
		case (opcode)
			op_special: begin
				reg_dst = 1'b1;
				reg_we = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sll: begin
						alu_op = alu_sll;
						use_rs = 1'b0;
					end
					fn_jr: begin
						is_jr = 1'b1;
						reg_we = 1'b0;
						use_rt = 1'b0;
					end
					default: begin
						reg_we = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
			end
			op_addiu, op_andi, op_ori, op_lui: begin
				alu_src = 1'b1;
				reg_we = 1'b1;
				use_rs = (opcode != op_lui);
				zero_ext = (opcode != op_addiu);
				alu_op = (opcode == op_addiu) ? alu_add :
				         (opcode == op_andi) ? alu_and :
				         (opcode == op_ori) ? alu_or : alu_lui;
			end
			op_lw, op_lh, op_lb: begin
				alu_src = 1'b1;
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
				reg_we = 1'b1;
				use_rs = 1'b1;
				load_kind = (opcode == op_lw) ? ld_word :
				            (opcode == op_lh) ? ld_half : ld_byte;
			end
			op_sw: begin
				alu_src = 1'b1;
				mem_write = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			op_beq, op_bne: begin
				is_beq = (opcode == op_beq);
				is_bne = (opcode == op_bne);
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			op_j: is_jimm = 1'b1;
			op_jal: begin
				is_jimm = 1'b1;
				link = 1'b1;
				alu_op = alu_pass_b;
				reg_we = 1'b1;
			end
			default: ;
		endcase
	end

	// register file, r0 hardwired, same-cycle write visible to read
	always_ff @(posedge i_clk) begin
		if (i_wb_we && i_wb_dst != '0) begin
			rf[i_wb_dst] <= i_wb_data;
		end
	end

	assign rs_rf = (rs == '0) ? '0 : (i_wb_we && i_wb_dst == rs) ? i_wb_data : rf[rs];
	assign rt_rf = (rt == '0) ? '0 : (i_wb_we && i_wb_dst == rt) ? i_wb_data : rf[rt];

	// branch operands take the memory-stage ALU result
	assign rs_val = (i_m_we && !i_m_load && i_m_dst != '0 && i_m_dst == rs) ? i_m_alu_res : rs_rf;
	assign rt_val = (i_m_we && !i_m_load && i_m_dst != '0 && i_m_dst == rt) ? i_m_alu_res : rt_rf;

	assign load_use = i_e_load && i_e_dst != '0 &&
		((use_rs && i_e_dst == rs) || (use_rt && i_e_dst == rt));

	// branch and jr compare here, so their sources must be settled one stage earlier
	assign br_hazard = (is_beq || is_bne || is_jr) && (
		(i_e_we && i_e_dst != '0 && (i_e_dst == rs || (use_rt && i_e_dst == rt))) ||
		(i_m_load && i_m_dst != '0 && (i_m_dst == rs || (use_rt && i_m_dst == rt))));

	assign o_stall = load_use || br_hazard;
	assign o_branch_taken = !o_stall && ((is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val));
	assign o_branch_target = i_pc4 + {imm_ext[29:0], 2'b00};
	assign o_jump = !o_stall && (is_jimm || is_jr);
	assign o_jump_target = is_jr ? rs_val : {i_pc4[31:28], i_instr[25:0], 2'b00};

	// bubble on stall
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_alu_op <= alu_add;
			o_alu_src <= 1'b0;
			o_reg_dst <= 1'b0;
			o_link <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_load_kind <= ld_word;
			o_mem_to_reg <= 1'b0;
			o_reg_we <= 1'b0;
		end else if (o_stall) begin
			o_alu_op <= alu_add;
			o_alu_src <= 1'b0;
			o_reg_dst <= 1'b0;
			o_link <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_load_kind <= ld_word;
			o_mem_to_reg <= 1'b0;
			o_reg_we <= 1'b0;
		end else begin
			o_alu_op <= alu_op;
			o_alu_src <= alu_src;
			o_reg_dst <= reg_dst;
			o_link <= link;
			o_mem_read <= mem_read;
			o_mem_write <= mem_write;
			o_load_kind <= load_kind;
			o_mem_to_reg <= mem_to_reg;
			o_reg_we <= reg_we;
		end
	end

	always_ff @(posedge i_clk) begin
		o_rs_data <= rs_rf;
		o_rt_data <= rt_rf;
		o_rs <= rs;
		o_rt <= rt;
		o_rd <= rd;
		o_imm <= imm_ext;
		o_pc4 <= i_pc4;
	end

	// fetch keeps the same word in decode while stalled
	a_stall_holds: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_stall |=> $stable(i_instr));

endmodule

//--- hdl/execute.sv
`timescale 1ns/100ps

module execute import mips_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [c_xlen-1:0]       i_rs_data,
	input  logic [c_xlen-1:0]       i_rt_data,
	input  logic [c_reg_addr_w-1:0] i_rs,
	input  logic [c_reg_addr_w-1:0] i_rt,
	input  logic [c_reg_addr_w-1:0] i_rd,
	input  logic [c_xlen-1:0]       i_imm,
	input  logic [c_xlen-1:0]       i_pc4,
	input  t_alu_op                 i_alu_op,
	input  logic                    i_alu_src,
	input  logic                    i_reg_dst,
	input  logic                    i_link,
	input  logic                    i_mem_read,
	input  logic                    i_mem_write,
	input  t_load_kind              i_load_kind,
	input  logic                    i_mem_to_reg,
	input  logic                    i_reg_we,
	input  logic [c_xlen-1:0]       i_fm_data,
	input  logic [c_reg_addr_w-1:0] i_fm_dst,
	input  logic                    i_fm_we,
	input  logic [c_xlen-1:0]       i_fw_data,
	input  logic [c_reg_addr_w-1:0] i_fw_dst,
	input  logic                    i_fw_we,
	output logic [c_xlen-1:0]       o_alu_res,
	output logic [c_xlen-1:0]       o_store_data,
	output logic [c_reg_addr_w-1:0] o_dst,
	output logic                    o_mem_read,
	output logic                    o_mem_write,
	output t_load_kind              o_load_kind,
	output logic                    o_mem_to_reg,
	output logic                    o_reg_we
);

	logic [c_xlen-1:0] op_a;
	logic [c_xlen-1:0] rt_fwd;
	logic [c_xlen-1:0] op_b;
	logic [c_xlen-1:0] alu_res;
	logic [c_reg_addr_w-1:0] dst;

	// memory stage wins over writeback, r0 never forwarded
	function automatic logic [c_xlen-1:0] fwd(
		input logic [c_reg_addr_w-1:0] idx,
		input logic [c_xlen-1:0] rf_val,
		input logic [c_xlen-1:0] m_data,
		input logic [c_reg_addr_w-1:0] m_dst,
		input logic m_we,
		input logic [c_xlen-1:0] w_data,
		input logic [c_reg_addr_w-1:0] w_dst,
		input logic w_we
	);
		if (idx == '0) return '0;
		if (m_we && m_dst == idx) return m_data;
		if (w_we && w_dst == idx) return w_data;
		return rf_val;
	endfunction

	assign op_a = fwd(i_rs, i_rs_data, i_fm_data, i_fm_dst, i_fm_we, i_fw_data, i_fw_dst, i_fw_we);
	assign rt_fwd = fwd(i_rt, i_rt_data, i_fm_data, i_fm_dst, i_fm_we, i_fw_data, i_fw_dst, i_fw_we);

	// jal links pc+8, past the delay slot
	assign op_b = i_link ? i_pc4 + 32'd4 : i_alu_src ? i_imm : rt_fwd;

	always_comb begin
		case (i_alu_op)
			alu_add:    alu_res = op_a + op_b;
			alu_sub:    alu_res = op_a - op_b;
			alu_and:    alu_res = op_a & op_b;
			alu_or:     alu_res = op_a | op_b;
			alu_xor:    alu_res = op_a ^ op_b;
			alu_slt:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_sll:    alu_res = op_b << i_imm[10:6];
			alu_lui:    alu_res = {op_b[15:0], 16'h0000};
			default:    alu_res = op_b;
		endcase
	end

	assign dst = i_link ? 5'd31 : i_reg_dst ? i_rd : i_rt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_load_kind <= ld_word;
			o_mem_to_reg <= 1'b0;
			o_reg_we <= 1'b0;
		end else begin
			o_mem_read <= i_mem_read;
			o_mem_write <= i_mem_write;
			o_load_kind <= i_load_kind;
			o_mem_to_reg <= i_mem_to_reg;
			o_reg_we <= i_reg_we;
		end
	end

	always_ff @(posedge i_clk) begin
		o_alu_res <= alu_res;
		o_store_data <= rt_fwd;
		o_dst <= dst;
	end

	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_mem_read && o_mem_write));

endmodule

//--- hdl/mem.sv
`timescale 1ns/100ps

module mem import mips_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [c_xlen-1:0]       i_alu_res,
	input  logic [c_xlen-1:0]       i_read_data,
	input  logic [c_reg_addr_w-1:0] i_dst,
	input  t_load_kind              i_load_kind,
	input  logic                    i_mem_to_reg,
	input  logic                    i_reg_we,
	output logic [c_xlen-1:0]       o_wb_data,
	output logic [c_reg_addr_w-1:0] o_wb_dst,
	output logic                    o_wb_we
);

	logic [7:0] byte_sel;
	logic [15:0] half_sel;
	logic [c_xlen-1:0] load_val;
	logic [c_xlen-1:0] load_q;
	logic [c_xlen-1:0] alu_q;
	logic mem_to_reg_q;

	// little endian lanes
	assign byte_sel = i_read_data[{i_alu_res[1:0], 3'b000} +: 8];
	assign half_sel = i_alu_res[1] ? i_read_data[31:16] : i_read_data[15:0];

	always_comb begin
		case (i_load_kind)
			ld_byte: load_val = {{24{byte_sel[7]}}, byte_sel};
			ld_half: load_val = {{16{half_sel[15]}}, half_sel};
			default: load_val = i_read_data;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mem_to_reg_q <= 1'b0;
			o_wb_we <= 1'b0;
		end else begin
			mem_to_reg_q <= i_mem_to_reg;
			o_wb_we <= i_reg_we;
		end
	end

	always_ff @(posedge i_clk) begin
		load_q <= load_val;
		alu_q <= i_alu_res;
		o_wb_dst <= i_dst;
	end

	// writeback mux
	assign o_wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

//--- hdl/core.sv
`timescale 1ns/100ps

module core import mips_pkg::*; #(
	parameter logic [c_xlen-1:0] P_RESET_ADDR = 32'h0000_0000
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic [c_xlen-1:0] i_instr,
	input  logic [c_xlen-1:0] i_read_data,
	output logic [c_xlen-1:0] o_instr_addr,
	output logic [c_xlen-1:0] o_data_addr,
	output logic [c_xlen-1:0] o_write_data,
	output logic              o_mem_write,
	output logic              o_mem_read
);

	// fetch to decode
	logic [c_xlen-1:0] f_instr;
	logic [c_xlen-1:0] f_pc4;
	logic stall;
	logic branch_taken;
	logic [c_xlen-1:0] branch_target;
	logic jump;
	logic [c_xlen-1:0] jump_target;

	// decode to execute
	logic [c_xlen-1:0] d_rs_data;
	logic [c_xlen-1:0] d_rt_data;
	logic [c_reg_addr_w-1:0] d_rs;
	logic [c_reg_addr_w-1:0] d_rt;
	logic [c_reg_addr_w-1:0] d_rd;
	logic [c_xlen-1:0] d_imm;
	logic [c_xlen-1:0] d_pc4;
	t_alu_op d_alu_op;
	logic d_alu_src;
	logic d_reg_dst;
	logic d_link;
	logic d_mem_read;
	logic d_mem_write;
	t_load_kind d_load_kind;
	logic d_mem_to_reg;
	logic d_reg_we;
	logic [c_reg_addr_w-1:0] d_dst;

	// execute to memory
	logic [c_reg_addr_w-1:0] e_dst;
	t_load_kind e_load_kind;
	logic e_mem_to_reg;
	logic e_reg_we;

	// writeback
	logic [c_xlen-1:0] wb_data;
	logic [c_reg_addr_w-1:0] wb_dst;
	logic wb_we;

	// destination of the instruction now in execute, for hazard checks in decode
	assign d_dst = d_link ? 5'd31 : d_reg_dst ? d_rd : d_rt;

	fetch #(
		.P_RESET_ADDR(P_RESET_ADDR)
	) u_fetch (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_stall(stall),
		.i_branch_taken(branch_taken),
		.i_branch_target(branch_target),
		.i_jump(jump),
		.i_jump_target(jump_target),
		.i_instr(i_instr),
		.o_instr_addr(o_instr_addr),
		.o_pc4(f_pc4),
		.o_instr_d(f_instr)
	);

	decode u_decode (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_instr(f_instr),
		.i_pc4(f_pc4),
		.i_wb_we(wb_we),
		.i_wb_dst(wb_dst),
		.i_wb_data(wb_data),
		.i_m_alu_res(o_data_addr),
		.i_m_dst(e_dst),
		.i_m_we(e_reg_we),
		.i_m_load(o_mem_read),
		.i_e_dst(d_dst),
		.i_e_we(d_reg_we),
		.i_e_load(d_mem_read),
		.o_stall(stall),
		.o_branch_taken(branch_taken),
		.o_branch_target(branch_target),
		.o_jump(jump),
		.o_jump_target(jump_target),
		.o_rs_data(d_rs_data),
		.o_rt_data(d_rt_data),
		.o_rs(d_rs),
		.o_rt(d_rt),
		.o_rd(d_rd),
		.o_imm(d_imm),
		.o_pc4(d_pc4),
		.o_alu_op(d_alu_op),
		.o_alu_src(d_alu_src),
		.o_reg_dst(d_reg_dst),
		.o_link(d_link),
		.o_mem_read(d_mem_read),
		.o_mem_write(d_mem_write),
		.o_load_kind(d_load_kind),
		.o_mem_to_reg(d_mem_to_reg),
		.o_reg_we(d_reg_we)
	);

	execute u_execute (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rs_data(d_rs_data),
		.i_rt_data(d_rt_data),
		.i_rs(d_rs),
		.i_rt(d_rt),
		.i_rd(d_rd),
		.i_imm(d_imm),
		.i_pc4(d_pc4),
		.i_alu_op(d_alu_op),
		.i_alu_src(d_alu_src),
		.i_reg_dst(d_reg_dst),
		.i_link(d_link),
		.i_mem_read(d_mem_read),
		.i_mem_write(d_mem_write),
		.i_load_kind(d_load_kind),
		.i_mem_to_reg(d_mem_to_reg),
		.i_reg_we(d_reg_we),
		.i_fm_data(o_data_addr),
		.i_fm_dst(e_dst),
		.i_fm_we(e_reg_we),
		.i_fw_data(wb_data),
		.i_fw_dst(wb_dst),
		.i_fw_we(wb_we),
		.o_alu_res(o_data_addr),
		.o_store_data(o_write_data),
		.o_dst(e_dst),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_load_kind(e_load_kind),
		.o_mem_to_reg(e_mem_to_reg),
		.o_reg_we(e_reg_we)
	);

	mem u_mem (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_alu_res(o_data_addr),
		.i_read_data(i_read_data),
		.i_dst(e_dst),
		.i_load_kind(e_load_kind),
		.i_mem_to_reg(e_mem_to_reg),
		.i_reg_we(e_reg_we),
		.o_wb_data(wb_data),
		.o_wb_dst(wb_dst),
		.o_wb_we(wb_we)
	);

endmodule

//--- bench/core_tb.sv
`timescale 1ns/100ps

module core_tb import mips_pkg::*; ();

	localparam logic [31:0] c_reset_addr = 32'h0000_0400;
	localparam int c_imem_base = 256;
	localparam int c_drain = 6;
	localparam int c_cycles_per_word = 40;
	localparam string c_test_file = "bench/core_tests.dat";

	logic i_clk;
	logic i_arst_n;
	logic [31:0] i_instr;
	logic [31:0] i_read_data;
	logic [31:0] o_instr_addr;
	logic [31:0] o_data_addr;
	logic [31:0] o_write_data;
	logic o_mem_write;
	logic o_mem_read;

	logic [31:0] imem [1024];
	logic [31:0] dmem [256];

	logic [31:0] prog_q [$];
	logic [31:0] data_addr_q [$];
	logic [31:0] data_val_q [$];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	string test_name;

	int errors;
	int tests_run;
	int tests_failed;
	int total_words;
	int limit_cycles;
	int count_fd;
	int run_fd;

	core #(
		.P_RESET_ADDR(c_reset_addr)
	) i_core (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_instr(i_instr),
		.i_read_data(i_read_data),
		.o_instr_addr(o_instr_addr),
		.o_data_addr(o_data_addr),
		.o_write_data(o_write_data),
		.o_mem_write(o_mem_write),
		.o_mem_read(o_mem_read)
	);

	// both memories answer in the same cycle
	assign i_instr = imem[o_instr_addr[11:2]];
	assign i_read_data = dmem[o_data_addr[9:2]];

	always @(posedge i_clk) begin
		if (o_mem_write) begin
			dmem[o_data_addr[9:2]] <= o_write_data;
		end
	end

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge i_clk);
		$display("simulation timed out after %0d cycles", limit_cycles);
		$display("Done: errors found");
		$finish;
	end

	task automatic count_program_words(input int fd, output int words);
		int code;
		logic [8*160-1:0] line;
		logic [8*32-1:0] tag;
		words = 0;
		while (!$feof(fd)) begin
			line = '0;
			tag = '0;
			code = $fgets(line, fd);
			if (code > 0) begin
				code = $sscanf(line, "%s", tag);
			end
			if (code > 0 && tag == "P") begin
				words++;
			end
		end
	endtask

	task automatic check_store(input int idx);
		assert (idx < exp_addr_q.size()) else begin
			$display("%0s: unexpected extra store to %h", test_name, o_data_addr);
			errors++;
		end
		if (idx < exp_addr_q.size()) begin
			assert (o_data_addr == exp_addr_q[idx] && o_write_data == exp_data_q[idx]) else begin
				$display("ERROR %0s: store %0d expected %h=%h, actual %h=%h", test_name, idx,
					exp_addr_q[idx], exp_data_q[idx], o_data_addr, o_write_data);
				errors++;
			end
		end
	endtask

	task automatic run_test;
		int k;
		int seen;
		int drain;
		int errs_before;
		bit done;
		errs_before = errors;
		@(posedge i_clk);
		i_arst_n <= 1'b0;
		// unused words jump to themselves, so a program ends by running off its end
		for (k = 0; k < 1024; k++) begin
			imem[k] = {op_j, 26'(k)};
		end
		for (k = 0; k < prog_q.size(); k++) begin
			imem[c_imem_base + k] = prog_q[k];
		end
		for (k = 0; k < 256; k++) begin
			dmem[k] <= 32'hd5a0_0000 ^ 32'(k * 4);
		end
		for (k = 0; k < data_addr_q.size(); k++) begin
			dmem[data_addr_q[k][9:2]] <= data_val_q[k];
		end
		repeat (2) @(posedge i_clk);
		i_arst_n <= 1'b1;
		@(negedge i_clk);
		assert (o_instr_addr == c_reset_addr) else begin
			$display("ERROR %0s: reset address expected %h, actual %h", test_name,
				c_reset_addr, o_instr_addr);
			errors++;
		end
		assert (!o_mem_write && !o_mem_read) else begin
			$display("%0s: memory access active right after reset", test_name);
			errors++;
		end
		seen = 0;
		drain = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge i_clk);
			if (o_mem_write) begin
				check_store(seen);
				seen++;
			end
			// older instructions still in flight after the self-jump
			if (drain > 0) begin
				drain--;
				done = (drain == 0);
			end else if (i_instr == {op_j, o_instr_addr[27:2]}) begin
				drain = c_drain;
			end
		end
		assert (seen == exp_addr_q.size()) else begin
			$display("%0s: saw %0d stores but %0d were expected", test_name, seen,
				exp_addr_q.size());
			errors++;
		end
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
		end
		$display("test %0s: %0s, %0d stores", test_name,
			(errors == errs_before) ? "pass" : "fail", seen);
	endtask

	task automatic read_and_run(input int fd);
		int code;
		logic [8*160-1:0] line;
		logic [8*32-1:0] tag;
		logic [8*32-1:0] word;
		logic [31:0] a;
		logic [31:0] b;
		while (!$feof(fd)) begin
			line = '0;
			tag = '0;
			code = $fgets(line, fd);
			if (code > 0) begin
				code = $sscanf(line, "%s", tag);
			end
			if (code > 0) begin
				if (tag == "T") begin
					word = '0;
					code = $sscanf(line, "%s %s", tag, word);
					test_name = string'(word);
					prog_q.delete();
					data_addr_q.delete();
					data_val_q.delete();
					exp_addr_q.delete();
					exp_data_q.delete();
				end else if (tag == "P") begin
					code = $sscanf(line, "%s %h", tag, a);
					prog_q.push_back(a);
				end else if (tag == "D") begin
					code = $sscanf(line, "%s %h %h", tag, a, b);
					data_addr_q.push_back(a);
					data_val_q.push_back(b);
				end else if (tag == "S") begin
					code = $sscanf(line, "%s %h %h", tag, a, b);
					exp_addr_q.push_back(a);
					exp_data_q.push_back(b);
				end else if (tag == "E") begin
					run_test();
				end
			end
		end
	endtask

	initial begin
		i_arst_n = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		limit_cycles = 0;
		count_fd = $fopen(c_test_file, "r");
		run_fd = $fopen(c_test_file, "r");
		if (count_fd == 0 || run_fd == 0) begin
			$display("cannot open test file %0s", c_test_file);
			$display("Done: errors found");
			$finish;
		end else begin
			count_program_words(count_fd, total_words);
			$fclose(count_fd);
			limit_cycles = c_cycles_per_word * total_words;
			read_and_run(run_fd);
			$fclose(run_fd);
			$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
			if (errors == 0 && tests_run > 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

//--- bench/core_tests.dat
# T name | P instruction word | D data address and word | S expected store address and data
# E ends a test, all values hex, program starts at 0x400
T alu
P 24010007
P 2402fffd
P 00221821
P 00222023
P 00222824
P 00223025
P 00223826
P 0041402a
P 00014900
P 304a00f0
P 342b8000
P 3c0c1234
P ac030200
P ac040204
P ac050208
P ac06020c
P ac070210
P ac080214
P ac090218
P ac0a021c
P ac0b0220
P ac0c0224
S 200 00000004
S 204 0000000a
S 208 00000005
S 20c ffffffff
S 210 fffffffa
S 214 00000001
S 218 00000070
S 21c 000000f0
S 220 00008007
S 224 12340000
E
T forward
P 24010005
P 00211021
P 00411821
P 00622023
P ac040300
P ac030304
P ac020308
S 300 00000005
S 304 0000000f
S 308 0000000a
E
T loads
D 40 80ff7f01
D 44 00000020
P 8c010044
P 24220001
P 80030040
P 80040041
P 80050042
P 80060043
P 84070040
P 84080042
P ac020340
P ac030344
P ac040348
P ac05034c
P ac060350
P ac070354
P ac080358
S 340 00000021
S 344 00000001
S 348 0000007f
S 34c ffffffff
S 350 ffffff80
S 354 00007f01
S 358 ffff80ff
E
T control
P 24010001
P 24020002
P 10220003
P 24030011
P ac030380
P 14220003
P 24040022
P 24040033
P 24040044
P ac040384
P 0800010d
P 24070077
P 24070088
P ac070394
P 0c000115
P 24050055
P ac050388
P ac1f038c
P ac060390
P 08000113
P 00000000
P 03e00008
P 24060066
S 380 00000011
S 384 00000022
S 394 00000077
S 388 00000055
S 38c 00000440
S 390 00000066
E
T reg_zero
P 2400005a
P ac0003c0
P 3c00ffff
P ac0003c4
S 3c0 00000000
S 3c4 00000000
E

//--- list.f
hdl/mips_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem.sv
hdl/core.sv
bench/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= Done: errors found
PASS_MSG ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
